//--- list.f
+incdir+hdl
hdl/fsab_pkg.sv
hdl/fsab_ingress.sv
hdl/mem_sequencer.sv
hdl/app_mem.sv
hdl/read_return.sv
hdl/fsab_mem.sv
sim/fsab_mem_chk.sv
sim/tb_fsab_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the fsab_mem testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_fsab_mem -f list.f -o tb_fsab_mem

# keep going on a nonzero exit so the log is still scanned
status=0
./obj_dir/tb_fsab_mem > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

//--- sim/tb_fsab_mem.sv
`timescale 1ns/1ps
`include "fsab_defs.svh"

module tb_fsab_mem import fsab_pkg::*; ();

	localparam int TIMEOUT = 2000; // cycles allowed per wait

	logic clk = 1'b0;
	logic rst_b;
	logic fsabo_valid;
	fsab_req_t fsabo_req;
	word_t fsabo_data;
	mask_t fsabo_mask;
	logic fsabo_credit;
	logic fsabi_valid;
	fsab_resp_t fsabi_resp;
	logic mem_ready;

	logic [31:0] lfsr_q = 32'd94584;
	logic [7:0] ref_mem [4096]; // byte image of the low 4 KiB
	fsab_resp_t exp_q [$]; // words owed by issued reads, in order
	fsab_resp_t exp_resp;
	word_t wdata [8]; // staged words for the next write
	mask_t wmask [8];
	int credits; // held by the master
	int credit_pulses;
	int resp_words; // response words seen so far
	string cur_test;

	fsab_mem i_fsab_mem (
		.clk(clk), .rst_b(rst_b),
		.fsabo_valid(fsabo_valid), .fsabo_req(fsabo_req),
		.fsabo_data(fsabo_data), .fsabo_mask(fsabo_mask),
		.fsabo_credit(fsabo_credit), .fsabi_valid(fsabi_valid),
		.fsabi_resp(fsabi_resp), .mem_ready(mem_ready)
	);

	bind fsab_mem fsab_mem_chk i_fsab_mem_chk (
		.clk(clk), .rst_b(rst_b), .fsabo_valid(fsabo_valid), .fsabo_req(fsabo_req),
		.fsabo_credit(fsabo_credit), .fsabi_valid(fsabi_valid),
		.fsabi_resp(fsabi_resp), .mem_ready(mem_ready)
	);

	always #2 clk = ~clk; // 4 ns period

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		if (exp !== act)
			abort_run($sformatf("mismatch in %s: expected %h actual %h", name, exp, act));
	endtask

	// fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			r = {r[62:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic word_t ref_word(input addr_t a);
		word_t w;
		for (int i = 0; i < 8; i++)
			w[8*i +: 8] = ref_mem[a[11:0] + 12'(i)]; // byte 0 in the low lane
		return w;
	endfunction

	// background pattern, every address bit shows
	function automatic word_t bg_word(input addr_t a);
		return {a ^ 32'h5ac3_0f00, ~a};
	endfunction

	task automatic put_beat(input logic v, input fsab_req_t r, input word_t d, input mask_t m);
		@(posedge clk);
		#0.5;
		fsabo_valid = v;
		fsabo_req = r;
		fsabo_data = d;
		fsabo_mask = m;
	endtask

	task automatic take_credit();
		int t;
		t = 0;
		while (credits == 0 && t < TIMEOUT) begin
			@(posedge clk);
			#0.5;
			t++;
		end
		if (credits == 0)
			abort_run($sformatf("timeout in %s: no credit came back", cur_test));
		else
			credits--;
	endtask

	task automatic wait_credit_pulses(input int n);
		int t;
		t = 0;
		while (credit_pulses < n && t < TIMEOUT) begin
			@(posedge clk);
			#0.5;
			t++;
		end
		if (credit_pulses < n)
			abort_run($sformatf("timeout in %s: credit pulse %0d never came", cur_test, n));
	endtask

	task automatic send_write(input addr_t addr, input int len, input did_t did,
		input did_t sub, input logic gaps);
		fsab_req_t r;
		int idle;
		r.mode = mode_write;
		r.did = did;
		r.subdid = sub;
		r.addr = addr;
		r.len = len_t'(len);
		take_credit();
		for (int w = 0; w < len; w++) begin
			for (int i = 0; i < 8; i++)
				if (!wmask[w][i])
					ref_mem[addr[11:0] + 12'(8*w + i)] = wdata[w][8*i +: 8];
			put_beat(1'b1, r, wdata[w], wmask[w]);
			idle = (gaps && w < len - 1) ? int'(rand_bits(2)) : 0; // stall between words
			repeat (idle) put_beat(1'b0, r, '0, '0);
		end
		put_beat(1'b0, r, '0, '0);
	endtask

	task automatic send_read(input addr_t addr, input int len, input did_t did, input did_t sub);
		fsab_req_t r;
		fsab_resp_t e;
		r.mode = mode_read;
		r.did = did;
		r.subdid = sub;
		r.addr = addr;
		r.len = len_t'(len);
		take_credit();
		for (int w = 0; w < len; w++) begin
			e.did = did;
			e.subdid = sub;
			e.data = ref_word(addr + addr_t'(8*w)); // memory is in order, so snapshot now
			exp_q.push_back(e);
		end
		put_beat(1'b1, r, '0, '0);
		put_beat(1'b0, r, '0, '0);
	endtask

	// all read words back and every credit home
	task automatic drain();
		int t;
		t = 0;
		while ((exp_q.size() != 0 || credits != `FSAB_CREDITS) && t < TIMEOUT) begin
			@(posedge clk);
			#0.5;
			t++;
		end
		if (exp_q.size() != 0)
			abort_run($sformatf("timeout in %s: %0d read words never came back",
				cur_test, exp_q.size()));
		else if (credits != `FSAB_CREDITS)
			abort_run($sformatf("timeout in %s: only %0d credits came back", cur_test, credits));
	endtask

	task automatic wait_ready();
		int t;
		t = 0;
		while (!mem_ready && t < TIMEOUT) begin
			@(posedge clk);
			#0.5;
			t++;
		end
		if (!mem_ready)
			abort_run("timeout: memory never reported ready");
	endtask

	// credit return and response compare on the edge
	always @(posedge clk) begin
		if (fsabo_credit) begin
			credits++;
			credit_pulses++;
			if (credits > `FSAB_CREDITS)
				abort_run($sformatf("credit in %s with nothing outstanding", cur_test));
		end
		if (fsabi_valid) begin
			resp_words++;
			if (exp_q.size() == 0) begin
				abort_run($sformatf("response word in %s with no read pending", cur_test));
			end else begin
				exp_resp = exp_q.pop_front();
				check_value(cur_test, 128'(exp_resp), 128'(fsabi_resp));
			end
		end
	end

	task automatic fill_background();
		cur_test = "fill";
		for (int b = 0; b < 16; b++) begin
			for (int w = 0; w < 8; w++) begin
				wdata[w] = bg_word(addr_t'(64*b + 8*w));
				wmask[w] = '0;
			end
			send_write(addr_t'(64*b), 8, 4'h0, 4'h0, 1'b0);
		end
		drain();
	endtask

	task automatic test_basic();
		cur_test = "basic";
		for (int w = 0; w < 8; w++) begin
			wdata[w] = word_t'(rand_bits(64));
			wmask[w] = '0;
		end
		send_write(32'h040, 8, 4'h1, 4'h2, 1'b0);
		send_read(32'h040, 8, 4'h3, 4'h5);
		drain();
	endtask

	task automatic test_odd_len();
		addr_t at [3];
		cur_test = "odd_len";
		at[0] = 32'h100;
		at[1] = 32'h110;
		at[2] = 32'h130;
		for (int k = 0; k < 3; k++) begin
			for (int w = 0; w < 8; w++) begin
				wdata[w] = word_t'(rand_bits(64));
				wmask[w] = '0;
			end
			send_write(at[k], 2*k + 1, did_t'(k), 4'ha, 1'b0);
		end
		for (int k = 0; k < 3; k++)
			send_read(at[k], 2*k + 1, did_t'(k + 4), 4'hb);
		// pad slots at 0x108, 0x128 and 0x158 must be untouched
		send_read(32'h100, 8, 4'h7, 4'h1);
		send_read(32'h140, 8, 4'h7, 4'h2);
		drain();
	endtask

	task automatic test_masks();
		cur_test = "masks";
		for (int w = 0; w < 4; w++) begin
			wdata[w] = word_t'(rand_bits(64));
			wmask[w] = mask_t'(rand_bits(8));
		end
		send_write(32'h200, 4, 4'h6, 4'h7, 1'b1);
		send_read(32'h200, 4, 4'h8, 4'h9);
		drain();
	endtask

	task automatic test_credits();
		int base;
		int words_base;
		cur_test = "credits";
		base = credit_pulses;
		words_base = resp_words;
		for (int k = 0; k < 4; k++)
			send_read(addr_t'(32'h300 + 16*k), 2, did_t'(k), 4'hc);
		check_value(cur_test, 128'(0), 128'(credits));
		// pulse k lands right after the last word of read k
		for (int k = 1; k <= 4; k++) begin
			wait_credit_pulses(base + k);
			check_value(cur_test, 128'(2*k), 128'(resp_words - words_base));
		end
		drain();
		repeat (10) @(posedge clk); // a stray pulse would show here
		#0.5;
	endtask

	task automatic test_mixed();
		int len;
		addr_t addr;
		did_t did;
		did_t sub;
		cur_test = "mixed";
		for (int n = 0; n < 24; n++) begin
			len = int'(rand_bits(3)) + 1;
			addr = addr_t'(rand_bits(5)) << 4; // stays inside the filled area
			did = did_t'(rand_bits(4));
			sub = did_t'(rand_bits(4));
			if (rand_bits(1) == 64'd1) begin
				for (int w = 0; w < len; w++) begin
					wdata[w] = word_t'(rand_bits(64));
					wmask[w] = mask_t'(rand_bits(8));
				end
				send_write(addr, len, did, sub, 1'b1);
			end else begin
				send_read(addr, len, did, sub);
			end
		end
		drain();
	endtask

	initial begin
		rst_b = 1'b0;
		fsabo_valid = 1'b0;
		fsabo_req = '0;
		fsabo_data = '0;
		fsabo_mask = '0;
		credits = `FSAB_CREDITS;
		credit_pulses = 0;
		resp_words = 0;
		cur_test = "reset";
		repeat (4) @(posedge clk);
		#0.5;
		rst_b = 1'b1;
		wait_ready();
		fill_background();
		test_basic();
		test_odd_len();
		test_masks();
		test_credits();
		test_mixed();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- sim/fsab_mem_chk.sv
`timescale 1ns/1ps
`include "fsab_defs.svh"

module fsab_mem_chk import fsab_pkg::*; (
	input logic       clk,
	input logic       rst_b,
	input logic       fsabo_valid,
	input fsab_req_t  fsabo_req,
	input logic       fsabo_credit,
	input logic       fsabi_valid,
	input fsab_resp_t fsabi_resp,
	input logic       mem_ready
);

	len_t words_due; // trailing write words still to come
	logic [3:0] outstanding; // accepted, credit not back yet
	logic hdr;

	assign hdr = fsabo_valid && (words_due == '0);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			words_due <= '0;
			outstanding <= '0;
		end else begin
			if (hdr && fsabo_req.mode == mode_write)
				words_due <= fsabo_req.len - len_t'(1);
			else if (fsabo_valid && words_due != '0)
				words_due <= words_due - len_t'(1);
			case ({hdr, fsabo_credit})
				2'b10: outstanding <= outstanding + 4'd1;
				2'b01: outstanding <= outstanding - 4'd1;
				default: ;
			endcase
		end
	end

	credit_one_cycle: assert property (@(posedge clk) disable iff (!rst_b)
		fsabo_credit |=> !fsabo_credit) else $error("credit held high for two cycles");

	resp_after_ready: assert property (@(posedge clk) disable iff (!rst_b)
		fsabi_valid |-> mem_ready) else $error("response word before memory ready");

	// master side never runs ahead of its credits
	within_credits: assert property (@(posedge clk) disable iff (!rst_b)
		outstanding <= 4'(`FSAB_CREDITS)) else $error("more requests in flight than credits");

	resp_known: assert property (@(posedge clk) disable iff (!rst_b)
		fsabi_valid |-> !$isunknown(fsabi_resp)) else $error("response word has x or z bits");

endmodule

//--- hdl/fsab_mem.sv
`timescale 1ns/1ps
`include "fsab_defs.svh"

module fsab_mem import fsab_pkg::*; (
	input  logic       clk,
	input  logic       rst_b,
	input  logic       fsabo_valid,
	input  fsab_req_t  fsabo_req,
	input  word_t      fsabo_data,
	input  mask_t      fsabo_mask,
	output logic       fsabo_credit,
	output logic       fsabi_valid,
	output fsab_resp_t fsabi_resp,
	output logic       mem_ready
);

	// ingress to sequencer
	logic req_avail;
	logic req_pop;
	logic beat_pop;
	fsab_req_t req;
	app_beat_t beat;

	// sequencer to app side
	logic cmd_wr;
	logic wdf_wr;
	app_cmd_t cmd;
	app_beat_t wbeat;

	logic init_done;
	logic af_afull;
	logic rd_valid;
	word_t [1:0] rd_beat;

	// read bookkeeping
	logic tag_push;
	logic rd_done;
	rd_tag_t tag;

	fsab_ingress i_ingress (
		.clk(clk), .rst_b(rst_b),
		.in_valid(fsabo_valid), .in_req(fsabo_req), .in_data(fsabo_data), .in_mask(fsabo_mask),
		.req_pop(req_pop), .beat_pop(beat_pop),
		.req_avail(req_avail), .req(req), .beat(beat)
	);

	mem_sequencer i_seq (
		.clk(clk), .rst_b(rst_b),
		.req_avail(req_avail), .req(req), .beat(beat),
		.init_done(init_done), .af_afull(af_afull), .rd_done(rd_done),
		.req_pop(req_pop), .beat_pop(beat_pop),
		.cmd_wr(cmd_wr), .cmd(cmd), .wdf_wr(wdf_wr), .wbeat(wbeat),
		.tag_push(tag_push), .tag(tag), .credit(fsabo_credit)
	);

	app_mem i_app_mem (
		.clk(clk), .rst_b(rst_b),
		.cmd_wr(cmd_wr), .cmd(cmd), .wdf_wr(wdf_wr), .wbeat(wbeat),
		.init_done(init_done), .af_afull(af_afull), .rd_valid(rd_valid), .rd_beat(rd_beat)
	);

	read_return i_read_return (
		.clk(clk), .rst_b(rst_b),
		.tag_push(tag_push), .tag(tag), .rd_valid(rd_valid), .rd_beat(rd_beat),
		.resp_valid(fsabi_valid), .resp(fsabi_resp), .rd_done(rd_done)
	);

	assign mem_ready = init_done;

endmodule

//--- hdl/read_return.sv
`timescale 1ns/1ps
`include "fsab_defs.svh"

module read_return import fsab_pkg::*; (
	input  logic        clk,
	input  logic        rst_b,
	input  logic        tag_push,
	input  rd_tag_t     tag,
	input  logic        rd_valid,
	input  word_t [1:0] rd_beat,
	output logic        resp_valid,
	output fsab_resp_t  resp,
	output logic        rd_done
);

	// beats come in twice as fast as words go out
	localparam int BB_DEPTH = (1 << (`FSAB_LEN_W - 1)) / 2; // longest read in beats
	localparam int BB_AW = $clog2(BB_DEPTH);

	word_t [1:0] bb_mem [BB_DEPTH];
	logic [BB_AW-1:0] bb_wr;
	logic [BB_AW-1:0] bb_rd;
	logic [BB_AW:0] bb_cnt;

	did_t cur_did;
	did_t cur_subdid;
	len_t words_left;
	logic half; // word select within head beat
	logic emit;
	logic last;
	logic pop;

	assign emit = (bb_cnt != '0) && (words_left != '0);
	assign last = (words_left == len_t'(1));
	// odd length drops the pad half with the beat
	assign pop = emit && (half || last);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			bb_wr <= '0;
			bb_rd <= '0;
			bb_cnt <= '0;
			words_left <= '0;
			half <= 1'b0;
			resp_valid <= 1'b0;
			rd_done <= 1'b0;
		end else begin
			if (rd_valid)
				bb_wr <= bb_wr + 1'b1;
			if (pop)
				bb_rd <= bb_rd + 1'b1;
			case ({rd_valid, pop})
				2'b10: bb_cnt <= bb_cnt + 1'b1;
				2'b01: bb_cnt <= bb_cnt - 1'b1;
				default: ;
			endcase

			if (tag_push)
				words_left <= tag.len;
			else if (emit)
				words_left <= words_left - len_t'(1);

			if (pop)
				half <= 1'b0;
			else if (emit)
				half <= 1'b1;

			resp_valid <= emit;
			rd_done <= emit && last; // same cycle as the final word
		end
	end

	always_ff @(posedge clk) begin
		if (rd_valid)
			bb_mem[bb_wr] <= rd_beat;
		if (tag_push) begin
			cur_did <= tag.did;
			cur_subdid <= tag.subdid;
		end
		if (emit) begin
			resp.did <= cur_did;
			resp.subdid <= cur_subdid;
			resp.data <= bb_mem[bb_rd][half];
		end
	end

endmodule

//--- hdl/app_mem.sv
`timescale 1ns/1ps
`include "fsab_defs.svh"

module app_mem import fsab_pkg::*; (
	input  logic        clk,
	input  logic        rst_b,
	input  logic        cmd_wr,
	input  app_cmd_t    cmd,
	input  logic        wdf_wr,
	input  app_beat_t   wbeat,
	output logic        init_done,
	output logic        af_afull,
	output logic        rd_valid,
	output word_t [1:0] rd_beat // [0] is the even word
);

	localparam int INIT_W = $clog2(`MEM_INIT_CYCLES + 1);
	localparam int LAT_W = $clog2(`MEM_RD_LAT);

	word_t [1:0] mem [2**`MEM_ADDR_W];

	logic [INIT_W-1:0] init_cnt;
	logic [`MEM_ADDR_W-1:0] wr_ptr; // next beat of a running write
	logic [`MEM_ADDR_W-1:0] wr_addr;
	logic [`MEM_ADDR_W-1:0] rd_ptr;
	len_t rd_left; // beats still to return
	logic [LAT_W-1:0] rd_lat;
	logic rd_cmd;
	logic rd_fire;

	assign rd_cmd = cmd_wr && (cmd.mode == mode_read);
	// first write beat arrives alongside its command
	assign wr_addr = (cmd_wr && cmd.mode == mode_write) ? cmd.addr[`MEM_ADDR_W-1:0] : wr_ptr;
	assign rd_fire = (rd_lat == '0) && (rd_left != '0);
	assign af_afull = (rd_left != '0); // busy until the last beat is back

	// stand-in for phy calibration
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			init_cnt <= '0;
			init_done <= 1'b0;
		end else if (!init_done) begin
			init_cnt <= init_cnt + 1'b1;
			if (init_cnt == INIT_W'(`MEM_INIT_CYCLES - 1))
				init_done <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			rd_left <= '0;
			rd_lat <= '0;
			rd_valid <= 1'b0;
		end else begin
			if (wdf_wr)
				wr_ptr <= wr_addr + 1'b1;
			rd_valid <= rd_fire;
			if (rd_cmd) begin
				rd_ptr <= cmd.addr[`MEM_ADDR_W-1:0];
				rd_left <= cmd.addr[$bits(beat_addr_t)-1 -: `FSAB_LEN_W];
				rd_lat <= LAT_W'(`MEM_RD_LAT - 2); // one for load, one for rd_valid flop
			end else if (rd_lat != '0) begin
				rd_lat <= rd_lat - 1'b1;
			end else if (rd_fire) begin
				rd_ptr <= rd_ptr + 1'b1;
				rd_left <= rd_left - len_t'(1);
			end
		end
	end

	// byte merge, mask bit set keeps the old byte
	always_ff @(posedge clk) begin
		if (wdf_wr) begin
			for (int i = 0; i < `FSAB_MASK_W; i++) begin
				if (!wbeat.mask_lo[i])
					mem[wr_addr][0][8*i +: 8] <= wbeat.data_lo[8*i +: 8];
				if (!wbeat.mask_hi[i])
					mem[wr_addr][1][8*i +: 8] <= wbeat.data_hi[8*i +: 8];
			end
		end
		if (rd_fire)
			rd_beat <= mem[rd_ptr];
	end

endmodule

//--- hdl/mem_sequencer.sv
`timescale 1ns/1ps
`include "fsab_defs.svh"

module mem_sequencer import fsab_pkg::*; (
	input  logic      clk,
	input  logic      rst_b,
	input  logic      req_avail,
	input  fsab_req_t req,
	input  app_beat_t beat, // data fifo head, one cycle after beat_pop
	input  logic      init_done,
	input  logic      af_afull,
	input  logic      rd_done,
	output logic      req_pop,
	output logic      beat_pop,
	output logic      cmd_wr,
	output app_cmd_t  cmd,
	output logic      wdf_wr,
	output app_beat_t wbeat,
	output logic      tag_push,
	output rd_tag_t   tag,
	output logic      credit
);

	seq_state_t state;
	len_t beats_left; // write beats incl. the one on wdf_wr now
	len_t nbeats;
	logic start;

	assign nbeats = (req.len + len_t'(1)) >> 1; // ceil(len/2)

	// one request in flight at a time
	assign start = (state == seq_idle) && req_avail && init_done && !af_afull;

	assign req_pop = start;
	// header and first entry leave together, then the rest of the burst
	assign beat_pop = start || (state == seq_wr_burst && beats_left != len_t'(1));

	// a read pops its pad entry too but it is never written
	assign wdf_wr = (state == seq_wr_burst);
	assign wbeat = beat;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state <= seq_idle;
			beats_left <= '0;
			cmd_wr <= 1'b0;
			tag_push <= 1'b0;
			credit <= 1'b0;
		end else begin
			cmd_wr <= start; // cmd goes out the cycle after the pop
			tag_push <= start && (req.mode == mode_read);
			credit <= 1'b0;
			case (state)
				seq_idle: begin
					if (start) begin
						beats_left <= nbeats;
						state <= (req.mode == mode_write) ? seq_wr_burst : seq_rd_wait;
					end
				end
				seq_wr_burst: begin
					beats_left <= beats_left - len_t'(1);
					if (beats_left == len_t'(1)) begin
						state <= seq_idle;
						credit <= 1'b1; // last beat is out
					end
				end
				seq_rd_wait: begin
					if (rd_done) begin
						state <= seq_idle;
						credit <= 1'b1; // last word is out
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			cmd.mode <= req.mode;
			// beat count rides in the spare top bits
			cmd.addr <= {nbeats, req.addr[`FSAB_ADDR_W-`FSAB_LEN_W-1:4]};
			tag.did <= req.did;
			tag.subdid <= req.subdid;
			tag.len <= req.len;
		end
	end

endmodule

//--- hdl/fsab_ingress.sv
`timescale 1ns/1ps
`include "fsab_defs.svh"

module fsab_ingress import fsab_pkg::*; (
	input  logic      clk,
	input  logic      rst_b,
	input  logic      in_valid,
	input  fsab_req_t in_req,
	input  word_t     in_data,
	input  mask_t     in_mask,
	input  logic      req_pop,
	input  logic      beat_pop,
	output logic      req_avail,
	output fsab_req_t req,
	output app_beat_t beat
);

	localparam int RQ_AW = $clog2(`FSAB_CREDITS);
	localparam int DF_AW = $clog2(`IDFIF_DEPTH);

	len_t rem; // words still owed by the current write
	logic hdr; // first beat of a request
	logic dat; // trailing write word
	logic is_wr;
	logic last; // final word of this request
	logic pair; // odd word completes a beat
	logic push;
	app_beat_t push_beat;

	// even word waiting for its partner
	logic hold_vld;
	word_t hold_data;
	mask_t hold_mask;

	fsab_req_t rq_mem [`FSAB_CREDITS]; // one slot per credit
	logic [RQ_AW-1:0] rq_wr;
	logic [RQ_AW-1:0] rq_rd;

	app_beat_t df_mem [`IDFIF_DEPTH];
	logic [DF_AW-1:0] df_wr;
	logic [DF_AW-1:0] df_rd;

	logic [RQ_AW:0] q_cnt; // requests fully in the data fifo

	assign hdr = in_valid && (rem == '0);
	assign dat = in_valid && (rem != '0);
	assign is_wr = (in_req.mode == mode_write); // only looked at on hdr

	// reads and single-word writes end on their header
	assign last = hdr ? (!is_wr || in_req.len == len_t'(1)) : (rem == len_t'(1));
	assign pair = dat && hold_vld;
	assign push = in_valid && (last || pair);

	always_comb begin
		if (pair) begin
			push_beat.data_hi = in_data;
			push_beat.mask_hi = in_mask;
			push_beat.data_lo = hold_data;
			push_beat.mask_lo = hold_mask;
		end else begin
			// even word ends the request so pad the upper half
			push_beat.data_hi = '0;
			push_beat.mask_hi = '1;
			push_beat.data_lo = in_data;
			push_beat.mask_lo = (hdr && !is_wr) ? '1 : in_mask; // read entry writes nothing
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			rem <= '0;
			hold_vld <= 1'b0;
			rq_wr <= '0;
			rq_rd <= '0;
			df_wr <= '0;
			df_rd <= '0;
			q_cnt <= '0;
		end else begin
			if (hdr && is_wr)
				rem <= in_req.len - len_t'(1);
			else if (dat)
				rem <= rem - len_t'(1);

			if (in_valid)
				hold_vld <= !push; // anything not pushed is parked

			if (hdr)
				rq_wr <= rq_wr + 1'b1;
			if (req_pop)
				rq_rd <= rq_rd + 1'b1;
			if (push)
				df_wr <= df_wr + 1'b1;
			if (beat_pop)
				df_rd <= df_rd + 1'b1;

			// visible to the sequencer once all its data is queued
			case ({push && last, req_pop})
				2'b10: q_cnt <= q_cnt + 1'b1;
				2'b01: q_cnt <= q_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && !push) begin
			hold_data <= in_data;
			hold_mask <= in_mask;
		end
		if (hdr)
			rq_mem[rq_wr] <= in_req;
		if (push)
			df_mem[df_wr] <= push_beat;
		if (beat_pop)
			beat <= df_mem[df_rd]; // one cycle behind the pop
	end

	assign req = rq_mem[rq_rd]; // head shows while req_avail
	assign req_avail = (q_cnt != '0);

endmodule

//--- hdl/fsab_pkg.sv
`include "fsab_defs.svh"

package fsab_pkg;

	typedef logic mode_t; // 1 = write
	typedef logic [`FSAB_DID_W-1:0] did_t;
	typedef logic [`FSAB_ADDR_W-1:0] addr_t;
	typedef logic [`FSAB_LEN_W-1:0] len_t;
	typedef logic [`FSAB_DATA_W-1:0] word_t;
	typedef logic [`FSAB_MASK_W-1:0] mask_t;
	typedef logic [`FSAB_ADDR_W-5:0] beat_addr_t; // byte addr / 16

	localparam mode_t mode_write = 1'b1;
	localparam mode_t mode_read = 1'b0;

	// header carried on the first beat of a request
	typedef struct packed {
		mode_t mode;
		did_t did;
		did_t subdid;
		addr_t addr;
		len_t len;
	} fsab_req_t;

	// one app-side beat, two fsab words
	typedef struct packed {
		word_t data_hi; // odd word
		mask_t mask_hi;
		word_t data_lo; // even word
		mask_t mask_lo;
	} app_beat_t;

	// the top FSAB_LEN_W bits of addr hold the burst length in beats
	// app_mem only decodes the low MEM_ADDR_W bits so they are free
	typedef struct packed {
		mode_t mode;
		beat_addr_t addr;
	} app_cmd_t;

	typedef struct packed {
		did_t did;
		did_t subdid;
		word_t data;
	} fsab_resp_t;

	// what read_return needs to route a read
	typedef struct packed {
		did_t did;
		did_t subdid;
		len_t len; // words, not beats
	} rd_tag_t;

	typedef enum logic [1:0] {
		seq_idle,
		seq_wr_burst,
		seq_rd_wait
	} seq_state_t;

endpackage

//--- hdl/fsab_defs.svh
`ifndef FSAB_DEFS_SVH
`define FSAB_DEFS_SVH

// fsab word and its byte mask
`define FSAB_DATA_W 64
`define FSAB_MASK_W 8 // 1 = byte not written

`define FSAB_ADDR_W 32 // byte address
`define FSAB_LEN_W 4 // words per request, 1..8
`define FSAB_DID_W 4 // did and subdid

// flow control
`define FSAB_CREDITS 4 // also request fifo depth
`define IDFIF_DEPTH 16 // credits * 4 beats

// behavioral memory model
`define MEM_ADDR_W 8 // log2 of array depth in beats
`define MEM_INIT_CYCLES 16 // reset to init done
`define MEM_RD_LAT 6 // read cmd to first beat

`endif
